// ==== filelist.f ====
+incdir+testbench
hw/cpu_pkg.sv
hw/regfile.sv
hw/decode_stage.sv
hw/bypass.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline_top.sv
testbench/tb_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_pipeline -o sim_pipeline
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_pipeline > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "All tests passed!" sim.log; then
	exit 0
fi
exit 1

// ==== testbench/cpu_model.svh ====
`ifndef cpu_model_svh
`define cpu_model_svh

localparam logic [4:0] rtype_op = 5'b00000;
localparam logic [4:0] addi_op  = 5'b00101;
localparam logic [4:0] sw_op    = 5'b00111;
localparam logic [4:0] lw_op    = 5'b01000;

logic [31:0] model_regs [32];
logic [31:0] model_mem [mem_words];
logic [4:0]  exp_rd [$];
logic [31:0] exp_data [$];

task automatic clear_state();
	for (int k = 0; k < 32; k++) begin
		model_regs[k] = 32'd0;
	end
	for (int k = 0; k < mem_words; k++) begin
		model_mem[k] = 32'd0;
	end
	exp_rd.delete();
	exp_data.delete();
endtask

function automatic logic [31:0] reg_value(logic [4:0] r);
	return (r == 5'd0) ? 32'd0 : model_regs[r];
endfunction

// executes one instruction in program order
task automatic run_model(logic [31:0] i);
	logic [4:0]  op;
	logic [4:0]  rd;
	logic [4:0]  fn;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] addr;
	logic [31:0] res;
	op   = i[31:27];
	rd   = i[26:22];
	fn   = i[6:2];
	a    = reg_value(i[21:17]);
	b    = reg_value(i[16:12]);
	imm  = {{15{i[16]}}, i[16:0]};
	addr = a + imm;
	res  = 32'd0;
	if (op == rtype_op) begin
		case (fn)
			5'b00001: res = a - b;
			5'b00010: res = a & b;
			5'b00011: res = a | b;
			default:  res = a + b;
		endcase
	end else if (op == addi_op) begin
		res = a + imm;
	end else if (op == lw_op) begin
		res = model_mem[addr[$clog2(mem_words)-1:0]];
	end else begin
		model_mem[addr[$clog2(mem_words)-1:0]] = reg_value(rd); // sw stores rd
	end
	if (op != sw_op && rd != 5'd0) begin
		model_regs[rd] = res;
		exp_rd.push_back(rd);
		exp_data.push_back(res);
	end
endtask

`endif

// ==== testbench/tb_pipeline.sv ====
module tb_pipeline;

	localparam int mem_words   = 64;
	localparam int n_insns     = 400;
	localparam int drive_limit = 4000;
	localparam int drain_limit = 50;

	`include "cpu_model.svh"

	logic        clock;
	logic        reset;
	logic        insn_valid;
	logic [31:0] insn;
	logic        insn_ready;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	integer      seed;
	logic        take;
	logic [4:0]  pending_ld; // rd of a lw now in decode/execute, 0 if none
	logic        exp_ready;
	logic [4:0]  want_rd;
	logic [31:0] want_data;
	logic [31:0] next_insn;
	logic [31:0] r;
	logic        done;
	int          sent = 0;
	int          cycles = 0;
	int          stalls = 0;
	int          wb_seen = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	pipeline_top #(.MEM_WORDS(mem_words)) UUT (
		.clock(clock), .reset(reset),
		.insn_valid(insn_valid), .insn(insn), .insn_ready(insn_ready),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// registers r0-r7 only, so hazards come often
	task automatic make_insn(output logic [31:0] i);
		logic [31:0] v;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		v   = $random(seed);
		rd  = {2'b00, v[2:0]};
		rs1 = {2'b00, v[5:3]};
		rs2 = {2'b00, v[8:6]};
		if (v[12:9] < 4'd6) begin
			i = {rtype_op, rd, rs1, rs2, 5'b00000, 3'b000, v[14:13], 2'b00};
		end else if (v[12:9] < 4'd10) begin
			i = {addi_op, rd, rs1, {9{v[20]}}, v[20:13]};
		end else begin
			if (v[17])
				rs1 = 5'd0; // base r0 keeps addresses small
			i = {(v[12:9] < 4'd13) ? lw_op : sw_op, rd, rs1, {13{v[16]}}, v[16:13]};
		end
	endtask

	always @(negedge clock) begin
		if (reset) begin
			take       = 1'b0;
			pending_ld = 5'd0;
		end else begin
			if (wb_valid) begin
				wb_seen++;
				assert (exp_rd.size() != 0)
				else begin
					other_errors++;
					$display("writeback to r%0d at %0t with no instruction left to retire",
						wb_rd, $time);
				end
				if (exp_rd.size() != 0) begin
					want_rd   = exp_rd.pop_front();
					want_data = exp_data.pop_front();
					assert (wb_rd == want_rd)
					else begin
						value_errors++;
						$display("FAILED time=%0t wb_rd expected=%0d actual=%0d",
							$time, want_rd, wb_rd);
					end
					assert (wb_data == want_data)
					else begin
						value_errors++;
						$display("FAILED time=%0t wb_data expected=%h actual=%h",
							$time, want_data, wb_data);
					end
				end
			end
			if (insn_valid) begin
				exp_ready = !(pending_ld != 5'd0 && (insn[21:17] == pending_ld
					|| (insn[31:27] == rtype_op && insn[16:12] == pending_ld)));
				if (!exp_ready)
					stalls++;
				assert (insn_ready == exp_ready)
				else begin
					value_errors++;
					$display("FAILED time=%0t insn_ready expected=%0b actual=%0b",
						$time, exp_ready, insn_ready);
				end
			end
			take = insn_valid && insn_ready; // transfer at the coming edge
			if (take)
				run_model(insn);
			pending_ld = (take && insn[31:27] == lw_op) ? insn[26:22] : 5'd0;
		end
	end

	initial begin
		seed       = 51;
		reset      = 1'b1;
		insn_valid = 1'b0;
		insn       = 32'd0;
		done       = 1'b0;
		clear_state();
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (!wb_valid && insn_ready)
		else begin
			other_errors++;
			$display("outputs not idle after reset");
		end

		while (!done && cycles < drive_limit) begin
			@(posedge clock);
			cycles++;
			if (!insn_valid || take) begin
				r = $random(seed);
				if (sent == n_insns) begin
					insn_valid <= 1'b0;
					done = 1'b1;
				end else if (r[1:0] == 2'b00) begin
					insn_valid <= 1'b0; // idle cycle
				end else begin
					make_insn(next_insn);
					insn_valid <= 1'b1;
					insn       <= next_insn;
					sent++;
				end
			end
		end
		if (!done) begin
			other_errors++;
			$display("instruction stream stuck, only %0d of %0d offered", sent, n_insns);
		end

		cycles = 0;
		while (exp_rd.size() != 0 && cycles < drain_limit) begin
			@(posedge clock);
			cycles++;
		end
		if (exp_rd.size() != 0) begin
			other_errors++;
			$display("%0d expected writebacks never appeared", exp_rd.size());
		end
		repeat (4) @(posedge clock); // catch stray writebacks

		$display("writebacks %0d, stalls %0d, value errors %0d, other errors %0d",
			wb_seen, stalls, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== hw/pipeline_top.sv ====
module pipeline_top
	import cpu_pkg::*;
#(
	parameter int MEM_WORDS = 64
) (
	input  logic      clock,
	input  logic      reset,
	input  logic      insn_valid,
	input  insn_t     insn,
	output logic      insn_ready,
	output logic      wb_valid,
	output reg_addr_t wb_rd,
	output word_t     wb_data
);

	dx_reg_t   dx;
	xm_reg_t   xm;
	mw_reg_t   mw;
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	logic      mx_a;
	logic      mx_b;
	logic      wx_a;
	logic      wx_b;
	logic      wm;

	assign wb_valid = mw.valid && writes_rd(mw.insn) && rd_of(mw.insn) != '0;
	assign wb_rd    = rd_of(mw.insn);
	assign wb_data  = mw.data;

	regfile u_regfile (
		.clock(clock), .reset(reset),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.wr_en(wb_valid), .wr_addr(wb_rd), .wr_data(wb_data)
	);

	decode_stage u_decode (
		.clock(clock), .reset(reset),
		.insn_valid(insn_valid), .insn(insn), .insn_ready(insn_ready),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.dx(dx)
	);

	bypass u_bypass (
		.dx(dx), .xm(xm), .mw(mw),
		.mx_a(mx_a), .mx_b(mx_b), .wx_a(wx_a), .wx_b(wx_b), .wm(wm)
	);

	execute_stage u_execute (
		.clock(clock), .reset(reset), .dx(dx),
		.xm_result(xm.result), .mw_data(mw.data),
		.mx_a(mx_a), .mx_b(mx_b), .wx_a(wx_a), .wx_b(wx_b),
		.xm(xm)
	);

	memory_stage #(.MEM_WORDS(MEM_WORDS)) u_memory (
		.clock(clock), .reset(reset), .xm(xm), .wm(wm), .mw(mw)
	);

endmodule

// ==== hw/memory_stage.sv ====
module memory_stage
	import cpu_pkg::*;
#(
	parameter int MEM_WORDS = 64
) (
	input  logic    clock,
	input  logic    reset,
	input  xm_reg_t xm,
	input  logic    wm,
	output mw_reg_t mw
);

	localparam int AW = $clog2(MEM_WORDS);

	word_t          ram [MEM_WORDS];
	logic  [AW-1:0] addr;
	word_t          store_data;
	logic           do_store;
	logic           is_load;

	assign addr       = xm.result[AW-1:0]; // wraps to ram depth
	assign store_data = wm ? mw.data : xm.store_data;
	assign do_store   = xm.valid && op_of(xm.insn) == op_sw;
	assign is_load    = op_of(xm.insn) == op_lw;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				ram[i] <= '0;
			end
		end else if (do_store) begin
			ram[addr] <= store_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mw <= '0;
		end else begin
			mw.valid <= xm.valid;
			mw.insn  <= xm.insn;
			mw.data  <= is_load ? ram[addr] : xm.result;
		end
	end

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage
	import cpu_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  dx_reg_t dx,
	input  word_t   xm_result,
	input  word_t   mw_data,
	input  logic    mx_a,
	input  logic    mx_b,
	input  logic    wx_a,
	input  logic    wx_b,
	output xm_reg_t xm
);

	word_t op_a;
	word_t op_b;
	word_t alu_out;
	word_t result;

	// youngest producer wins
	assign op_a = mx_a ? xm_result : (wx_a ? mw_data : dx.a);
	assign op_b = mx_b ? xm_result : (wx_b ? mw_data : dx.b);

	always_comb begin
		unique case (fn_of(dx.insn))
			fn_add:  alu_out = op_a + op_b;
			fn_sub:  alu_out = op_a - op_b;
			fn_and:  alu_out = op_a & op_b;
			fn_or:   alu_out = op_a | op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	// addi, lw and sw all use rs1 + imm
	assign result = (op_of(dx.insn) == op_rtype) ? alu_out : op_a + dx.imm;

	always_ff @(posedge clock) begin
		if (reset) begin
			xm <= '0;
		end else begin
			xm.valid      <= dx.valid;
			xm.insn       <= dx.insn;
			xm.result     <= result;
			xm.store_data <= op_b; // rd value for sw
		end
	end

endmodule

// ==== hw/bypass.sv ====
module bypass
	import cpu_pkg::*;
(
	input  dx_reg_t dx,
	input  xm_reg_t xm,
	input  mw_reg_t mw,
	output logic    mx_a,
	output logic    mx_b,
	output logic    wx_a,
	output logic    wx_b,
	output logic    wm
);

	reg_addr_t dx_rs1;
	reg_addr_t dx_b_src;
	reg_addr_t xm_rd;
	reg_addr_t mw_rd;
	logic      dx_uses_a;
	logic      dx_uses_b;
	logic      xm_fwd;
	logic      mw_fwd;
	logic      xm_load;
	logic      load_use;

	assign dx_rs1    = rs1_of(dx.insn);
	assign dx_b_src  = reads_rd(dx.insn) ? rd_of(dx.insn) : rs2_of(dx.insn);
	assign dx_uses_a = dx.valid && reads_rs1(dx.insn);
	assign dx_uses_b = dx.valid && (reads_rs2(dx.insn) || reads_rd(dx.insn));

	assign xm_rd   = rd_of(xm.insn);
	assign mw_rd   = rd_of(mw.insn);
	assign xm_load = xm.valid && op_of(xm.insn) == op_lw && xm_rd != '0;

	assign xm_fwd = xm.valid && writes_rd(xm.insn) && op_of(xm.insn) != op_lw
		&& xm_rd != '0; // load data not there yet
	assign mw_fwd = mw.valid && writes_rd(mw.insn) && mw_rd != '0;

	assign mx_a = dx_uses_a && xm_fwd && dx_rs1 == xm_rd;
	assign mx_b = dx_uses_b && xm_fwd && dx_b_src == xm_rd;
	assign wx_a = dx_uses_a && mw_fwd && dx_rs1 == mw_rd;
	assign wx_b = dx_uses_b && mw_fwd && dx_b_src == mw_rd;
	assign wm   = xm.valid && reads_rd(xm.insn) && mw_fwd && xm_rd == mw_rd;

	// a load-use pair here means decode let one through
	assign load_use = xm_load && dx.valid
		&& ((reads_rs1(dx.insn) && dx_rs1 == xm_rd)
		|| (reads_rs2(dx.insn) && rs2_of(dx.insn) == xm_rd));

	always_comb begin
		no_load_use: assert (!load_use)
			else $error("load result needed before it exists");
	end

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage
	import cpu_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      insn_valid,
	input  insn_t     insn,
	output logic      insn_ready,
	output reg_addr_t rd_addr_a,
	output reg_addr_t rd_addr_b,
	input  word_t     rd_data_a,
	input  word_t     rd_data_b,
	output dx_reg_t   dx
);

	reg_addr_t load_rd;
	logic      load_in_dx;
	logic      use_rs1;
	logic      use_rs2;
	logic      stall;
	word_t     imm;

	assign load_rd    = rd_of(dx.insn);
	assign load_in_dx = dx.valid && op_of(dx.insn) == op_lw && load_rd != '0;

	// sw reading rd is left out, W->M covers it
	assign use_rs1 = reads_rs1(insn) && rs1_of(insn) == load_rd;
	assign use_rs2 = reads_rs2(insn) && rs2_of(insn) == load_rd;
	assign stall   = load_in_dx && (use_rs1 || use_rs2);

	assign insn_ready = !stall;

	assign rd_addr_a = rs1_of(insn);
	assign rd_addr_b = reads_rd(insn) ? rd_of(insn) : rs2_of(insn);
	assign imm       = {{15{insn[16]}}, insn[16:0]};

	always_ff @(posedge clock) begin
		if (reset) begin
			dx <= '0;
		end else begin
			dx.valid <= insn_valid && !stall; // bubble while stalled
			dx.insn  <= insn;
			dx.a     <= rd_data_a;
			dx.b     <= rd_data_b;
			dx.imm   <= imm;
		end
	end

	// source must hold the offer until it is taken
	held_offer: assert property (@(posedge clock) disable iff (reset)
		insn_valid && !insn_ready |=> insn_valid && $stable(insn))
		else $error("insn changed while stalled");

endmodule

// ==== hw/regfile.sv ====
module regfile
	import cpu_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t rd_addr_a,
	input  reg_addr_t rd_addr_b,
	output word_t     rd_data_a,
	output word_t     rd_data_b,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [32];

	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (wr_en && wr_addr == addr)
			return wr_data; // write-through, covers W->D
		return regs[addr];
	endfunction

	assign rd_data_a = read_port(rd_addr_a);
	assign rd_data_b = read_port(rd_addr_b);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] insn_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;

	typedef enum logic [4:0] {
		op_rtype = 5'b00000,
		op_addi  = 5'b00101,
		op_sw    = 5'b00111,
		op_lw    = 5'b01000
	} opcode_t;

	typedef enum logic [4:0] {
		fn_add = 5'b00000,
		fn_sub = 5'b00001,
		fn_and = 5'b00010,
		fn_or  = 5'b00011
	} alu_fn_t;

	typedef struct packed {
		logic  valid;
		insn_t insn;
		word_t a;
		word_t b; // rs2, or rd for sw
		word_t imm;
	} dx_reg_t;

	typedef struct packed {
		logic  valid;
		insn_t insn;
		word_t result; // alu value or address
		word_t store_data;
	} xm_reg_t;

	typedef struct packed {
		logic  valid;
		insn_t insn;
		word_t data;
	} mw_reg_t;

	function automatic opcode_t op_of(insn_t i);
		return opcode_t'(i[31:27]);
	endfunction

	function automatic alu_fn_t fn_of(insn_t i);
		return alu_fn_t'(i[6:2]);
	endfunction

	function automatic reg_addr_t rd_of(insn_t i);
		return i[26:22];
	endfunction

	function automatic reg_addr_t rs1_of(insn_t i);
		return i[21:17];
	endfunction

	function automatic reg_addr_t rs2_of(insn_t i);
		return i[16:12];
	endfunction

	function automatic logic writes_rd(insn_t i);
		return op_of(i) inside {op_rtype, op_addi, op_lw};
	endfunction

	function automatic logic reads_rs1(insn_t i);
		return op_of(i) inside {op_rtype, op_addi, op_sw, op_lw};
	endfunction

	function automatic logic reads_rs2(insn_t i);
		return op_of(i) == op_rtype;
	endfunction

	function automatic logic reads_rd(insn_t i);
		return op_of(i) == op_sw; // store data comes from rd
	endfunction

endpackage
